// File: verilog/macc_pkg.sv
//--------------------------------------------------------------------------
// shared widths, word types and state encodings of the MAC sequencer
//--------------------------------------------------------------------------

package macc_pkg;

  //------------------------------------------------------------------------
  // widths
  //------------------------------------------------------------------------
  localparam int DATA_W     = 16;                  // operand word
  localparam int TAP_W      = 4;                   // tap counter
  localparam int CHAN_W     = 4;                   // filter / channel counter
  localparam int ACC_W      = 2 * DATA_W + TAP_W;  // product plus tap growth

  // issue to accumulator register, in cycles
  localparam int PIPE_DEPTH = 2;
  localparam int OPND_DLY   = PIPE_DEPTH - 1;      // operand stage depth
  localparam int DRAIN_W    = $clog2(PIPE_DEPTH + 1);

  //------------------------------------------------------------------------
  // word types
  //------------------------------------------------------------------------
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ACC_W-1:0]  acc_t;
  typedef logic [TAP_W-1:0]  tap_t;
  typedef logic [CHAN_W-1:0] chan_t;

  typedef enum logic [0:0] {
    OP_CONV = 1'b0,  // weight times ifmap over the taps
    OP_ACC  = 1'b1   // external plus internal psum
  } op_e;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    CONV_RUN  = 3'd1,  // one tap per cycle
    CONV_NEXT = 3'd2,  // step to next filter
    ACC_RUN   = 3'd3,  // one channel per cycle
    DRAIN     = 3'd4,  // wait for the pipeline to empty
    DONE      = 3'd5   // ack high until req falls
  } seq_state_e;

endpackage

// File: verilog/macc_seq_fsm.sv
//--------------------------------------------------------------------------
// MAC sequencer FSM, walks the tap and filter counters for one request
// and answers the four-phase start handshake
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module macc_seq_fsm (
  input  logic            clk,
  input  logic            rst,

  // start handshake
  input  logic            start_req,
  input  macc_pkg::op_e   start_op,
  input  macc_pkg::tap_t  conv_len,    // held while req is high
  input  macc_pkg::chan_t filter_num,  // held while req is high
  output logic            start_ack,

  // pad memory addresses
  output macc_pkg::tap_t  cnt_a,
  output macc_pkg::chan_t cnt_b,

  // term issue to the operand stage
  output logic            issue,
  output macc_pkg::op_e   issue_op,
  output logic            first_term,
  output logic            last_term,
  output macc_pkg::chan_t issue_index
);
  import macc_pkg::*;

  seq_state_e         state;
  seq_state_e         state_nxt;
  logic [DRAIN_W-1:0] drain_cnt;

  tap_t               len_m1;
  chan_t              filt_m1;
  logic               tap_last;
  logic               filt_last;
  logic               chan_last;

  assign len_m1    = conv_len - tap_t'(1);
  assign filt_m1   = filter_num - chan_t'(1);
  assign tap_last  = (cnt_a == len_m1);
  assign filt_last = (cnt_b == filt_m1);
  assign chan_last = (cnt_a == tap_t'(filt_m1));  // cnt_a walks channels in acc

  //------------------------------------------------------------------------
  // state register and next state
  //------------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (start_req) begin
          state_nxt = (start_op == OP_ACC) ? ACC_RUN : CONV_RUN;
        end
      end
      CONV_RUN: begin
        if (tap_last) begin
          state_nxt = filt_last ? DRAIN : CONV_NEXT;
        end
      end
      CONV_NEXT: begin
        state_nxt = CONV_RUN;
      end
      ACC_RUN: begin
        if (chan_last) begin
          state_nxt = DRAIN;
        end
      end
      DRAIN: begin
        if (drain_cnt == '0) begin
          state_nxt = DONE;
        end
      end
      DONE: begin
        if (!start_req) begin  // host has seen ack
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  //------------------------------------------------------------------------
  // tap, filter and drain counters
  //------------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_a     <= '0;
      cnt_b     <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        CONV_RUN: begin
          cnt_a     <= tap_last ? '0 : cnt_a + tap_t'(1);
          drain_cnt <= DRAIN_W'(PIPE_DEPTH - 1);  // armed for the last tap
        end
        CONV_NEXT: begin
          cnt_b <= cnt_b + chan_t'(1);
        end
        ACC_RUN: begin
          cnt_a     <= chan_last ? '0 : cnt_a + tap_t'(1);
          drain_cnt <= DRAIN_W'(PIPE_DEPTH - 1);
        end
        DRAIN: begin
          cnt_b     <= '0;
          drain_cnt <= drain_cnt - DRAIN_W'(1);
        end
        default: begin  // idle and done park at zero
          cnt_a <= '0;
          cnt_b <= '0;
        end
      endcase
    end
  end

  //------------------------------------------------------------------------
  // term control and ack
  //------------------------------------------------------------------------
  assign issue       = (state == CONV_RUN) || (state == ACC_RUN);
  assign issue_op    = (state == ACC_RUN) ? OP_ACC : OP_CONV;

  // every acc term is a whole result on its own
  assign first_term  = (state == ACC_RUN) || ((state == CONV_RUN) && (cnt_a == '0));
  assign last_term   = (state == ACC_RUN) || ((state == CONV_RUN) && tap_last);
  assign issue_index = (state == ACC_RUN) ? chan_t'(cnt_a) : cnt_b;

  assign start_ack   = (state == DONE);  // pipeline already empty here

endmodule

// File: verilog/macc_operand_stage.sv
//--------------------------------------------------------------------------
// operand capture for the MAC datapath with matching control delay line
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module macc_operand_stage (
  input  logic             clk,
  input  logic             rst,

  // term control from the sequencer
  input  logic             issue,
  input  macc_pkg::op_e    issue_op,
  input  logic             first_term,
  input  logic             last_term,
  input  macc_pkg::chan_t  issue_index,

  // pad memory data
  input  macc_pkg::data_t  weight_in,
  input  macc_pkg::data_t  ifmap_in,
  input  macc_pkg::data_t  external_psum,
  input  macc_pkg::data_t  internal_psum,

  // to the datapath
  output logic             term_valid,
  output macc_pkg::op_e    term_op,
  output logic             term_first,
  output logic             term_last,
  output macc_pkg::chan_t  term_index,
  output macc_pkg::data_t  opnd_a,
  output macc_pkg::data_t  opnd_b
);
  import macc_pkg::*;

  logic [OPND_DLY-1:0] vld_q;
  logic [OPND_DLY-1:0] op_q;
  logic [OPND_DLY-1:0] first_q;
  logic [OPND_DLY-1:0] last_q;
  chan_t               idx_q [OPND_DLY];
  data_t               a_q   [OPND_DLY];
  data_t               b_q   [OPND_DLY];

  // control bits, valid drops without issue
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld_q   <= '0;
      op_q    <= '0;
      first_q <= '0;
      last_q  <= '0;
    end else begin
      vld_q[0]   <= issue;
      op_q[0]    <= issue_op;
      first_q[0] <= issue & first_term;
      last_q[0]  <= issue & last_term;
      for (int i = 1; i < OPND_DLY; i++) begin
        vld_q[i]   <= vld_q[i-1];
        op_q[i]    <= op_q[i-1];
        first_q[i] <= first_q[i-1];
        last_q[i]  <= last_q[i-1];
      end
    end
  end

  // operand words hold between issues
  always_ff @(posedge clk) begin
    if (issue) begin
      idx_q[0] <= issue_index;
      a_q[0]   <= (issue_op == OP_CONV) ? weight_in : external_psum;
      b_q[0]   <= (issue_op == OP_CONV) ? ifmap_in  : internal_psum;
    end
    for (int i = 1; i < OPND_DLY; i++) begin
      idx_q[i] <= idx_q[i-1];
      a_q[i]   <= a_q[i-1];
      b_q[i]   <= b_q[i-1];
    end
  end

  assign term_valid = vld_q[OPND_DLY-1];
  assign term_op    = op_e'(op_q[OPND_DLY-1]);
  assign term_first = first_q[OPND_DLY-1];
  assign term_last  = last_q[OPND_DLY-1];
  assign term_index = idx_q[OPND_DLY-1];
  assign opnd_a     = a_q[OPND_DLY-1];
  assign opnd_b     = b_q[OPND_DLY-1];

endmodule

// File: verilog/macc_datapath.sv
//--------------------------------------------------------------------------
// MAC datapath, multiplier or adder term into a registered accumulator
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module macc_datapath (
  input  logic             clk,
  input  logic             rst,

  // term from the operand stage
  input  logic             term_valid,
  input  macc_pkg::op_e    term_op,
  input  logic             term_first,
  input  logic             term_last,
  input  macc_pkg::chan_t  term_index,
  input  macc_pkg::data_t  opnd_a,
  input  macc_pkg::data_t  opnd_b,

  // result stream, no back-pressure
  output logic             psum_valid,
  output macc_pkg::chan_t  psum_index,
  output macc_pkg::acc_t   psum_out
);
  import macc_pkg::*;

  logic [2*DATA_W-1:0] prod;
  logic [DATA_W:0]     opnd_sum;
  acc_t                term;
  acc_t                acc_nxt;
  acc_t                acc_q;

  //------------------------------------------------------------------------
  // term select and accumulate
  //------------------------------------------------------------------------
  assign prod     = opnd_a * opnd_b;                  // unsigned, full width
  assign opnd_sum = {1'b0, opnd_a} + {1'b0, opnd_b};  // carry kept
  assign term     = (term_op == OP_CONV) ? acc_t'(prod) : acc_t'(opnd_sum);
  assign acc_nxt  = term_first ? term : acc_q + term;  // first term restarts

  always_ff @(posedge clk) begin
    if (term_valid) begin
      acc_q <= acc_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (term_valid && term_last) begin
      psum_index <= term_index;
    end
  end

  // strobe lines up with the final sum in acc_q
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      psum_valid <= 1'b0;
    end else begin
      psum_valid <= term_valid & term_last;
    end
  end

  assign psum_out = acc_q;

endmodule

// File: verilog/macc_top.sv
//--------------------------------------------------------------------------
// MAC processing element top, sequencer plus operand stage plus datapath
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module macc_top (
  input  logic            clk,
  input  logic            rst,

  // start handshake and request parameters
  input  logic            start_req,
  input  macc_pkg::op_e   start_op,
  input  macc_pkg::tap_t  conv_len,
  input  macc_pkg::chan_t filter_num,
  output logic            start_ack,

  // pad memories, read combinationally from the counters
  output macc_pkg::tap_t  cnt_a,
  output macc_pkg::chan_t cnt_b,
  input  macc_pkg::data_t weight_in,
  input  macc_pkg::data_t ifmap_in,
  input  macc_pkg::data_t external_psum,
  input  macc_pkg::data_t internal_psum,

  // results
  output logic            psum_valid,
  output macc_pkg::chan_t psum_index,
  output macc_pkg::acc_t  psum_out
);
  import macc_pkg::*;

  // sequencer to operand stage
  logic  issue;
  op_e   issue_op;
  logic  first_term;
  logic  last_term;
  chan_t issue_index;

  // operand stage to datapath
  logic  term_valid;
  op_e   term_op;
  logic  term_first;
  logic  term_last;
  chan_t term_index;
  data_t opnd_a;
  data_t opnd_b;

  macc_seq_fsm u_seq (
    .clk         (clk),
    .rst         (rst),
    .start_req   (start_req),
    .start_op    (start_op),
    .conv_len    (conv_len),
    .filter_num  (filter_num),
    .start_ack   (start_ack),
    .cnt_a       (cnt_a),
    .cnt_b       (cnt_b),
    .issue       (issue),
    .issue_op    (issue_op),
    .first_term  (first_term),
    .last_term   (last_term),
    .issue_index (issue_index)
  );

  macc_operand_stage u_opnd (
    .clk           (clk),
    .rst           (rst),
    .issue         (issue),
    .issue_op      (issue_op),
    .first_term    (first_term),
    .last_term     (last_term),
    .issue_index   (issue_index),
    .weight_in     (weight_in),
    .ifmap_in      (ifmap_in),
    .external_psum (external_psum),
    .internal_psum (internal_psum),
    .term_valid    (term_valid),
    .term_op       (term_op),
    .term_first    (term_first),
    .term_last     (term_last),
    .term_index    (term_index),
    .opnd_a        (opnd_a),
    .opnd_b        (opnd_b)
  );

  macc_datapath u_dp (
    .clk        (clk),
    .rst        (rst),
    .term_valid (term_valid),
    .term_op    (term_op),
    .term_first (term_first),
    .term_last  (term_last),
    .term_index (term_index),
    .opnd_a     (opnd_a),
    .opnd_b     (opnd_b),
    .psum_valid (psum_valid),
    .psum_index (psum_index),
    .psum_out   (psum_out)
  );

endmodule

// File: verif/tb_macc_top.sv
//--------------------------------------------------------------------------
// testbench for the MAC processing element with pad memory models and
// directed convolution and accumulation requests over the start handshake
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_macc_top;
  import macc_pkg::*;

  localparam int WAIT_LIMIT = 1000;  // cycles per wait loop

  logic  clk;
  logic  rst;
  logic  start_req;
  op_e   start_op;
  tap_t  conv_len;
  chan_t filter_num;
  logic  start_ack;
  tap_t  cnt_a;
  chan_t cnt_b;
  data_t weight_in;
  data_t ifmap_in;
  data_t external_psum;
  data_t internal_psum;
  logic  psum_valid;
  chan_t psum_index;
  acc_t  psum_out;

  // pad memories read combinationally
  data_t weight_mem [16][16];  // [filter][tap]
  data_t ifmap_mem  [16];
  data_t ext_mem    [16];
  data_t int_mem    [16];

  assign weight_in     = weight_mem[cnt_b][cnt_a];
  assign ifmap_in      = ifmap_mem[cnt_a];
  assign external_psum = ext_mem[cnt_a];
  assign internal_psum = int_mem[cnt_a];

  macc_top dut (
    .clk           (clk),
    .rst           (rst),
    .start_req     (start_req),
    .start_op      (start_op),
    .conv_len      (conv_len),
    .filter_num    (filter_num),
    .start_ack     (start_ack),
    .cnt_a         (cnt_a),
    .cnt_b         (cnt_b),
    .weight_in     (weight_in),
    .ifmap_in      (ifmap_in),
    .external_psum (external_psum),
    .internal_psum (internal_psum),
    .psum_valid    (psum_valid),
    .psum_index    (psum_index),
    .psum_out      (psum_out)
  );

  always #50 clk = ~clk;  // 100 ns period

  //------------------------------------------------------------------------
  // memory fill, reference sums and reporting
  //------------------------------------------------------------------------
  task automatic fill_memories(input bit all_ones);
    for (int i = 0; i < 16; i++) begin
      for (int k = 0; k < 16; k++) begin
        weight_mem[i][k] = all_ones ? '1 : data_t'($urandom);
      end
      ifmap_mem[i] = all_ones ? '1 : data_t'($urandom);
      ext_mem[i]   = all_ones ? '1 : data_t'($urandom);
      int_mem[i]   = all_ones ? '1 : data_t'($urandom);
    end
  endtask

  // sum over taps of weight times ifmap for one filter
  function automatic acc_t conv_sum(input int f, input int len);
    acc_t s;
    s = '0;
    for (int k = 0; k < len; k++) begin
      s = s + acc_t'(weight_mem[f[3:0]][k[3:0]]) * acc_t'(ifmap_mem[k[3:0]]);
    end
    return s;
  endfunction

  function automatic acc_t acc_sum(input int c);
    return acc_t'(ext_mem[c[3:0]]) + acc_t'(int_mem[c[3:0]]);  // zero-extended
  endfunction

  task automatic check_value(input string what, input acc_t expected, input acc_t actual);
    assert (expected === actual) else begin
      $display("ERROR: %s expected 0x%0h actual 0x%0h", what, expected, actual);
      $display("sim failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("sim failed");
    $fatal(1, "wait timed out");
  endtask

  //------------------------------------------------------------------------
  // one request through the four-phase handshake from a falling edge
  //------------------------------------------------------------------------
  task automatic run_request(input string name, input op_e op, input int len, input int nf);
    int   got;
    int   cycles;
    acc_t expected;
    start_op   = op;
    conv_len   = tap_t'(len);
    filter_num = chan_t'(nf);
    start_req  = 1'b1;
    got    = 0;
    cycles = 0;
    while (!start_ack) begin
      @(negedge clk);
      cycles++;
      if (psum_valid) begin
        expected = (op == OP_CONV) ? conv_sum(got, len) : acc_sum(got);
        check_value({name, " index"}, acc_t'(got), acc_t'(psum_index));
        check_value({name, " psum"}, expected, psum_out);
        got++;
      end
      if (!start_ack && cycles > WAIT_LIMIT) begin
        report_timeout({name, " start_ack rise"});
      end
    end
    check_value({name, " result count"}, acc_t'(nf), acc_t'(got));
    // ack must hold while req is still high
    repeat (3) begin
      @(negedge clk);
      check_value({name, " ack hold"}, acc_t'(1), acc_t'(start_ack));
      check_value({name, " no strobe"}, acc_t'(0), acc_t'(psum_valid));
    end
    start_req = 1'b0;
    cycles    = 0;
    while (start_ack) begin
      @(negedge clk);
      cycles++;
      if (start_ack && cycles > WAIT_LIMIT) begin
        report_timeout({name, " start_ack fall"});
      end
    end
  endtask

  //------------------------------------------------------------------------
  // directed tests
  //------------------------------------------------------------------------
  task automatic reset_values();
    check_value("reset ack", acc_t'(0), acc_t'(start_ack));
    check_value("reset valid", acc_t'(0), acc_t'(psum_valid));
    check_value("reset cnt_a", acc_t'(0), acc_t'(cnt_a));
    check_value("reset cnt_b", acc_t'(0), acc_t'(cnt_b));
  endtask

  task automatic basic_conv();
    run_request("conv_5x3", OP_CONV, 5, 3);
  endtask

  task automatic basic_acc();
    run_request("acc_6", OP_ACC, 6, 6);
  endtask

  task automatic minimum_sizes();
    run_request("conv_1x1", OP_CONV, 1, 1);
    run_request("acc_1", OP_ACC, 1, 1);
  endtask

  task automatic maximum_sizes();
    fill_memories(1'b1);  // worst case growth
    run_request("conv_15x15_ones", OP_CONV, 15, 15);
    run_request("acc_15_ones", OP_ACC, 15, 15);
    fill_memories(1'b0);
  endtask

  task automatic back_to_back();
    run_request("b2b_conv_a", OP_CONV, 3, 4);
    run_request("b2b_acc_a", OP_ACC, 7, 9);
    run_request("b2b_conv_b", OP_CONV, 9, 2);
    run_request("b2b_acc_b", OP_ACC, 2, 3);
    run_request("b2b_conv_c", OP_CONV, 15, 5);
  endtask

  initial begin
    void'($urandom(33816));
    clk        = 1'b0;
    rst        = 1'b1;
    start_req  = 1'b0;
    start_op   = OP_CONV;
    conv_len   = '0;
    filter_num = '0;
    fill_memories(1'b0);
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    reset_values();
    basic_conv();
    basic_acc();
    minimum_sizes();
    maximum_sizes();
    back_to_back();
    $display("sim passed");
    $finish;
  end

endmodule

// File: filelist.f
verilog/macc_pkg.sv
verilog/macc_seq_fsm.sv
verilog/macc_operand_stage.sv
verilog/macc_datapath.sv
verilog/macc_top.sv
verif/tb_macc_top.sv

// File: Makefile
# Verilator build and run of the MAC processing element testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_macc_top
FILELIST  = filelist.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail is taken from the log
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
